// File: logic/controlTable.svh
// control table: base control-word patterns per sequencer state, indexed by T-state
`ifndef CONTROL_TABLE_SVH
`define CONTROL_TABLE_SVH

// single-bit masks from the package bit positions
localparam controlWordT cwNone      = '0;
localparam controlWordT cwPcInc     = controlWordT'(1) << ctlPcInc;
localparam controlWordT cwOpFetch   = controlWordT'(1) << ctlOpFetch;
localparam controlWordT cwAdlPcl    = controlWordT'(1) << ctlAdlPcl;
localparam controlWordT cwDbWrite   = controlWordT'(1) << ctlDbWrite;
localparam controlWordT cwVecFetch  = controlWordT'(1) << ctlVecFetch;
localparam controlWordT cwBranchAdd = controlWordT'(1) << ctlBranchAdd;

// entry 0 is never addressed, T-states start at 1

// reset: three stack reads with writes held off, then the vector
localparam controlWordT initTable [0:7] = '{
    cwNone, cwNone, cwNone, cwNone, cwNone,  // T0 to T4, dummy reads
    cwVecFetch,                              // T5 vector low
    cwVecFetch | cwAdlPcl,                   // T6 vector high
    cwAdlPcl                                 // T7 jump to the vector
};

// T1 fetch and T2 operand read, common to every class
localparam controlWordT fetchTable [0:7] = '{
    cwNone,
    cwPcInc | cwOpFetch,  // T1
    cwPcInc,              // T2
    cwNone, cwNone, cwNone, cwNone, cwNone
};

localparam controlWordT normTable [0:7] = '{
    cwNone, cwNone, cwNone,
    cwPcInc,    // T3 second operand byte
    cwAdlPcl,   // T4 effective address
    cwDbWrite,  // T5 store cycle on the longest forms
    cwNone, cwNone
};

localparam controlWordT rmwTable [0:7] = '{
    cwNone, cwNone, cwNone,
    cwAdlPcl,   // T3 read operand
    cwDbWrite,  // T4 dummy write of the old value
    cwDbWrite,  // T5 write the modified value
    cwNone, cwNone
};

// page fix is added by the ROM when acr is set in T3
localparam controlWordT branchTable [0:7] = '{
    cwNone, cwNone, cwNone,
    cwBranchAdd,  // T3 offset into PCL
    cwAdlPcl,     // T4 corrected PCH
    cwNone, cwNone, cwNone
};

localparam controlWordT brkTable [0:7] = '{
    cwNone, cwNone, cwNone,
    cwDbWrite,               // T3 push PCH
    cwDbWrite,               // T4 push PCL
    cwDbWrite,               // T5 push status
    cwVecFetch,              // T6 vector low
    cwVecFetch | cwAdlPcl    // T7 vector high
};

`endif

// File: logic/cpuCtlPkg.sv
// cpu control package: shared widths, state encodings and control-word layout
package cpuCtlPkg;

    // plain vector types with a meaning of their own
    typedef logic [7:0]  opcodeT;       // instruction opcode as fetched
    typedef logic [7:0]  statusT;       // N V - B D I Z C
    typedef logic [2:0]  tStateT;       // cycle index, 1 is the fetch cycle
    typedef logic [23:0] controlWordT;  // control lines for one cycle

    // instruction classes, each with its own cycle-length rule
    typedef enum logic [1:0] {
        classNorm   = 2'd0,  // fixed length, 2 + opcode[3:2]
        classRmw    = 2'd1,  // read-modify-write, always rmwCycles
        classBranch = 2'd2,  // relative branch, 2 to 4 cycles
        classBrk    = 2'd3   // software break or interrupt entry
    } instrClassT;

    // interrupt sources in the order the latch reports them
    typedef enum logic [1:0] {
        srcNone = 2'd0,
        srcRst  = 2'd1,  // reset sequence in progress
        srcNmi  = 2'd2,  // edge triggered
        srcIrq  = 2'd3   // level triggered
    } irqSrcT;

    // timing sequencer states
    typedef enum logic [2:0] {
        seqInit   = 3'd0,  // reset sequence
        seqFetch  = 3'd1,  // T1 opcode fetch and T2 decode
        seqNorm   = 3'd2,
        seqRmw    = 3'd3,
        seqBranch = 3'd4,
        seqBrk    = 3'd5
    } seqStateT;

    // bit positions inside controlWordT
    // upper bits are spare for datapath lines added later
    localparam int ctlPcInc     = 0;  // advance program counter
    localparam int ctlOpFetch   = 1;  // opcode on the data bus goes to the IR
    localparam int ctlAdlPcl    = 2;  // low address bus from PCL
    localparam int ctlDbWrite   = 3;  // drive the data bus, write cycle
    localparam int ctlVecFetch  = 4;  // address the interrupt vector
    localparam int ctlLateWrite = 5;  // register writeback left over from the last op
    localparam int ctlBranchAdd = 6;  // add the branch offset to PCL
    localparam int ctlPageFix   = 7;  // carry into PCH after a page cross

    // fixed opcodes and lengths
    localparam opcodeT brkOpcode = 8'h00;  // forced into the IR on interrupt entry
    localparam tStateT rmwCycles = 3'd5;
    localparam tStateT brkCycles = 3'd7;   // reset sequence has the same length

endpackage

// File: logic/predecodeReg.sv
// predecode register: captures the fetched opcode, or forces BRK when an interrupt waits
module predecodeReg (
    input  logic              phi1,
    input  logic              rst,
    input  logic              rdy,
    input  logic              t1Now,         // fetch cycle, opcode valid on the bus
    input  cpuCtlPkg::opcodeT opcode,
    input  cpuCtlPkg::irqSrcT pendingSrc,
    output cpuCtlPkg::opcodeT activeOpcode,  // IR contents from T2 on
    output cpuCtlPkg::opcodeT prevOpcode     // IR one enabled cycle ago
);
    import cpuCtlPkg::*;

    opcodeT fetchValue;  // value the IR takes at the end of this T1

    // an interrupt replaces the fetched byte, the PC is not advanced past it
    assign fetchValue = (pendingSrc != srcNone) ? brkOpcode : opcode;

    always_ff @(posedge phi1) begin
        if (rst) begin
            activeOpcode <= brkOpcode;
            prevOpcode   <= brkOpcode;
        end else if (rdy) begin
            // trails the IR by one cycle
            // in T1 it still names the instruction that just ended,
            // which is what the leftover writeback keys on
            prevOpcode <= activeOpcode;
            if (t1Now) begin
                activeOpcode <= fetchValue;  // load at the end of T1
            end
        end
    end

endmodule

// File: logic/instrClassifier.sv
// instruction classifier: opcode to class, normal length and branch decision
module instrClassifier (
    input  cpuCtlPkg::opcodeT     activeOpcode,
    input  cpuCtlPkg::statusT     statusReg,
    output cpuCtlPkg::instrClassT instrClass,
    output cpuCtlPkg::tStateT     normLength,   // cycles for classNorm
    output logic                  branchTaken   // condition met, branch classes only
);
    import cpuCtlPkg::*;

    // flag positions in the status register
    localparam int flagN = 7;
    localparam int flagV = 6;
    localparam int flagZ = 1;
    localparam int flagC = 0;

    logic condFlag;  // flag picked by opcode[7:6]

    // class rule, first match wins
    always_comb begin
        if (activeOpcode == brkOpcode) begin
            instrClass = classBrk;
        end else if (activeOpcode[4:0] == 5'b10000) begin
            instrClass = classBranch;  // BPL BMI BVC BVS BCC BCS BNE BEQ
        end else if ((activeOpcode[2:0] == 3'b110) && (activeOpcode[7:6] != 2'b10)) begin
            instrClass = classRmw;     // shifts, INC, DEC; the 10 row is LDX/STX
        end else begin
            instrClass = classNorm;
        end
    end

    // 2 to 5 cycles from the addressing-mode bits
    assign normLength = 3'd2 + {1'b0, activeOpcode[3:2]};

    // branch condition select, N V C Z order
    always_comb begin
        case (activeOpcode[7:6])
            2'b00:   condFlag = statusReg[flagN];
            2'b01:   condFlag = statusReg[flagV];
            2'b10:   condFlag = statusReg[flagC];
            default: condFlag = statusReg[flagZ];
        endcase
    end

    assign branchTaken = (condFlag == activeOpcode[5]);  // bit 5 is the wanted value

endmodule

// File: logic/interruptLatch.sv
// interrupt latch holding one pending source by priority and flagging it handled on service
module interruptLatch (
    input  logic              phi1,
    input  logic              rst,
    input  logic              nmi,
    input  logic              irq,
    input  logic              t1Now,
    input  logic              rdy,
    input  logic              serviceDone,  // last cycle of a BRK or reset sequence
    output cpuCtlPkg::irqSrcT pendingSrc,
    output logic              nmiHandled,
    output logic              irqHandled
);
    import cpuCtlPkg::*;

    logic nmiPrev;     // nmi level last cycle
    logic nmiReq;      // edge seen, not yet taken
    logic nmiEdge;     // request visible this cycle
    logic sampleNow;   // enabled T1 with nothing pending
    logic takeNmi;
    logic inService;   // pending source owns the BRK now running

    assign nmiEdge   = nmiReq || (nmi && !nmiPrev);
    assign sampleNow = t1Now && rdy && (pendingSrc == srcNone);
    assign takeNmi   = sampleNow && nmiEdge;

    always_ff @(posedge phi1) begin
        if (rst) begin
            pendingSrc <= srcRst;  // the reset sequence services this
            inService  <= 1'b1;
            nmiPrev    <= 1'b0;
            nmiReq     <= 1'b0;
        end else begin
            nmiPrev <= nmi;                    // edge detect runs on every cycle including stalls
            nmiReq  <= nmiEdge && !takeNmi;

            if (serviceDone && inService) begin
                pendingSrc <= srcNone;
                inService  <= 1'b0;
            end else if (t1Now && rdy) begin
                if (pendingSrc != srcNone) begin
                    inService <= 1'b1;         // predecode forces BRK at this fetch
                end else if (takeNmi) begin
                    pendingSrc <= srcNmi;      // nmi beats irq
                end else if (irq) begin
                    pendingSrc <= srcIrq;
                end
            end
        end
    end

    // high for one enabled cycle at the end of the BRK sequence
    assign nmiHandled = serviceDone && inService && (pendingSrc == srcNmi);
    assign irqHandled = serviceDone && inService && (pendingSrc == srcIrq);

    handledExclusive: assert property (@(posedge phi1) disable iff (rst)
        !(nmiHandled && irqHandled))
        else $error("nmi and irq reported handled together");

endmodule

// File: logic/timingSequencer.sv
// timing sequencer: T-state machine with reset sequence, RDY stall and end-of-instruction
module timingSequencer (
    input  logic                  phi1,
    input  logic                  rst,
    input  logic                  rdy,
    input  logic                  acr,          // address adder carry, page cross
    input  cpuCtlPkg::instrClassT instrClass,
    input  cpuCtlPkg::tStateT     normLength,
    input  logic                  branchTaken,
    output cpuCtlPkg::seqStateT   seqState,
    output cpuCtlPkg::tStateT     tState,
    output logic                  t1Now,
    output logic                  sync,
    output logic                  serviceDone,
    output logic                  resetActive
);
    import cpuCtlPkg::*;

    seqStateT stateNext;
    tStateT   tNext;
    logic     lastCycle;   // current cycle ends the instruction
    logic     shortInstr;  // decoded op is done after T2

    // 2-cycle ops never leave seqFetch
    always_comb begin
        case (instrClass)
            classNorm:   shortInstr = (normLength == 3'd2);
            classBranch: shortInstr = !branchTaken;  // not taken, 2 cycles
            default:     shortInstr = 1'b0;
        endcase
    end

    // end of instruction, per state
    always_comb begin
        case (seqState)
            seqInit:   lastCycle = (tState == brkCycles);
            seqFetch:  lastCycle = (tState == 3'd2) && shortInstr;
            seqNorm:   lastCycle = (tState == normLength);
            seqRmw:    lastCycle = (tState == rmwCycles);
            // acr in T3 picks 3 or 4 cycles
            seqBranch: lastCycle = (tState == 3'd4) || ((tState == 3'd3) && !acr);
            seqBrk:    lastCycle = (tState == brkCycles);
            default:   lastCycle = 1'b1;  // stray code recovers through fetch
        endcase
    end

    always_comb begin
        stateNext = seqState;
        tNext     = tState + 3'd1;
        if (lastCycle) begin
            stateNext = seqFetch;
            tNext     = 3'd1;
        end else if ((seqState == seqFetch) && (tState == 3'd2)) begin
            // IR loaded at the end of T1, so the class is known in T2
            case (instrClass)
                classNorm:   stateNext = seqNorm;
                classRmw:    stateNext = seqRmw;
                classBranch: stateNext = seqBranch;
                default:     stateNext = seqBrk;
            endcase
        end
    end

    always_ff @(posedge phi1) begin
        if (rst) begin
            seqState <= seqInit;
            tState   <= 3'd1;   // first reset cycle
            sync     <= 1'b0;
        end else if (rdy) begin  // rdy low freezes everything
            seqState <= stateNext;
            tState   <= tNext;
            sync     <= (stateNext == seqFetch) && (tNext == 3'd1);
        end
    end

    assign t1Now       = (seqState == seqFetch) && (tState == 3'd1);
    assign resetActive = (seqState == seqInit);

    // counted on enabled cycles only, so a stall cannot stretch the pulse
    assign serviceDone = rdy && (tState == brkCycles)
                       && ((seqState == seqBrk) || (seqState == seqInit));

    syncOnlyInFetch: assert property (@(posedge phi1) disable iff (rst)
        sync |-> (seqState == seqFetch) && t1Now)
        else $error("sync outside the fetch cycle");

    // the opcode is fetched once per instruction
    syncSingleCycle: assert property (@(posedge phi1) disable iff (rst)
        (sync && rdy) |=> !sync)
        else $error("sync high on two enabled cycles in a row");

endmodule

// File: logic/controlRom.sv
// control ROM: state and T-state to a registered control word, plus page fix and leftover write
module controlRom (
    input  logic                   phi1,
    input  logic                   rst,
    input  logic                   rdy,
    input  logic                   acr,
    input  cpuCtlPkg::seqStateT    seqState,
    input  cpuCtlPkg::tStateT      tState,
    input  cpuCtlPkg::opcodeT      prevOpcode,
    output cpuCtlPkg::controlWordT controlWord   // describes the previous enabled cycle
);
    import cpuCtlPkg::*;

    `include "controlTable.svh"

    controlWordT baseWord;   // table pattern
    controlWordT nextWord;   // with the cycle-dependent extras

    always_comb begin
        case (seqState)
            seqInit:   baseWord = initTable[tState];
            seqFetch:  baseWord = fetchTable[tState];
            seqNorm:   baseWord = normTable[tState];
            seqRmw:    baseWord = rmwTable[tState];
            seqBranch: baseWord = branchTable[tState];
            seqBrk:    baseWord = brkTable[tState];
            default:   baseWord = cwNone;
        endcase
    end

    always_comb begin
        nextWord = baseWord;
        // offset add carried out of PCL
        if ((seqState == seqBranch) && (tState == 3'd3) && acr) begin
            nextWord[ctlPageFix] = 1'b1;
        end
        // ALU-group result lands during T2 of the next instruction,
        // built here at the end of T1
        if ((seqState == seqFetch) && (tState == 3'd1) && (prevOpcode[1:0] == 2'b01)) begin
            nextWord[ctlLateWrite] = 1'b1;
        end
    end

    always_ff @(posedge phi1) begin
        if (rst) begin
            controlWord <= '0;
        end else if (rdy) begin
            controlWord <= nextWord;  // held through a stall
        end
    end

endmodule

// File: logic/cpuControl.sv
// cpu timing and control unit: interrupt latch, predecode, classifier, sequencer and control ROM
module cpuControl (
    input  logic                   phi1,
    input  logic                   rst,
    input  logic                   rdy,
    input  logic                   nmi,
    input  logic                   irq,
    input  logic                   acr,
    input  cpuCtlPkg::opcodeT      opcode,
    input  cpuCtlPkg::statusT      statusReg,
    output logic                   sync,
    output logic                   resetActive,
    output logic                   nmiHandled,
    output logic                   irqHandled,
    output cpuCtlPkg::opcodeT      activeOpcode,
    output cpuCtlPkg::controlWordT controlWord
);
    import cpuCtlPkg::*;

    irqSrcT     pendingSrc;
    logic       t1Now;
    logic       serviceDone;
    opcodeT     prevOpcode;
    instrClassT instrClass;
    tStateT     normLength;
    logic       branchTaken;
    seqStateT   seqState;
    tStateT     tState;

    interruptLatch interruptLatch_inst (
        .phi1(phi1), .rst(rst), .nmi(nmi), .irq(irq), .t1Now(t1Now), .rdy(rdy),
        .serviceDone(serviceDone), .pendingSrc(pendingSrc),
        .nmiHandled(nmiHandled), .irqHandled(irqHandled)
    );

    predecodeReg predecodeReg_inst (
        .phi1(phi1), .rst(rst), .rdy(rdy), .t1Now(t1Now), .opcode(opcode),
        .pendingSrc(pendingSrc), .activeOpcode(activeOpcode), .prevOpcode(prevOpcode)
    );

    instrClassifier instrClassifier_inst (
        .activeOpcode(activeOpcode), .statusReg(statusReg), .instrClass(instrClass),
        .normLength(normLength), .branchTaken(branchTaken)
    );

    timingSequencer timingSequencer_inst (
        .phi1(phi1), .rst(rst), .rdy(rdy), .acr(acr), .instrClass(instrClass),
        .normLength(normLength), .branchTaken(branchTaken), .seqState(seqState),
        .tState(tState), .t1Now(t1Now), .sync(sync), .serviceDone(serviceDone),
        .resetActive(resetActive)
    );

    controlRom controlRom_inst (
        .phi1(phi1), .rst(rst), .rdy(rdy), .acr(acr), .seqState(seqState),
        .tState(tState), .prevOpcode(prevOpcode), .controlWord(controlWord)
    );

endmodule

// File: verification/cpuControlTb.sv
// testbench driving the cpu timing and control unit through reset, cycle counts, stalls and interrupts
module cpuControlTb;
    timeunit 1ns;
    timeprecision 100ps;

    import cpuCtlPkg::*;

    localparam realtime clkPeriod = 4.0;
    localparam int      rowCount  = 21;

    logic        phi1;
    logic        rst;
    logic        rdy;
    logic        nmi;
    logic        irq;
    logic        acr;
    opcodeT      opcode;
    statusT      statusReg;
    logic        sync;
    logic        resetActive;
    logic        nmiHandled;
    logic        irqHandled;
    opcodeT      activeOpcode;
    controlWordT controlWord;

    integer seed;          // stall pattern source
    int     checkCount;
    int     errorCount;
    int     fillIdx;       // next free table row

    // one row of stimulus and expected values per instruction
    string      rowName    [rowCount];
    opcodeT     rowOpcode  [rowCount];
    statusT     rowStatus  [rowCount];
    logic       rowAcr     [rowCount];
    int         rowStalls  [rowCount];   // rdy-low cycles spread at random over the row
    logic [1:0] rowReq     [rowCount];   // {nmi, irq} levels held for the whole row
    int         rowLen     [rowCount];   // enabled cycles, sync to sync
    logic [1:0] rowHandled [rowCount];   // {nmi, irq} pulse expected in this row
    logic       rowLate    [rowCount];   // late write after the fetch
    logic       rowPageFix [rowCount];

    cpuControl cpuControl_inst (
        .phi1(phi1), .rst(rst), .rdy(rdy), .nmi(nmi), .irq(irq), .acr(acr),
        .opcode(opcode), .statusReg(statusReg), .sync(sync), .resetActive(resetActive),
        .nmiHandled(nmiHandled), .irqHandled(irqHandled), .activeOpcode(activeOpcode),
        .controlWord(controlWord)
    );

    initial begin
        phi1 = 1'b0;
        forever #(clkPeriod / 2) phi1 = ~phi1;
    end

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("CHECK FAILED %s: expected %h, actual %h", testName, expected, actual);
        end
    endtask

    task automatic addRow(input string name, input opcodeT op, input statusT st,
                          input logic carry, input int stalls, input logic [1:0] req,
                          input int len, input logic [1:0] handled, input logic late,
                          input logic pageFix);
        rowName[fillIdx]    = name;
        rowOpcode[fillIdx]  = op;
        rowStatus[fillIdx]  = st;
        rowAcr[fillIdx]     = carry;
        rowStalls[fillIdx]  = stalls;
        rowReq[fillIdx]     = req;
        rowLen[fillIdx]     = len;
        rowHandled[fillIdx] = handled;
        rowLate[fillIdx]    = late;
        rowPageFix[fillIdx] = pageFix;
        fillIdx++;
    endtask

    task automatic runReset();
        int         activeCycles;
        logic [6:0] vecMask;     // vector fetch seen in each reset cycle
        rst = 1'b1;
        repeat (8) @(posedge phi1);
        #0.5;
        checkValue("reset hold sync", 0, sync);
        checkValue("reset hold active", 1, resetActive);
        checkValue("reset hold control word", 0, controlWord);
        checkValue("reset hold handled flags", 0, {nmiHandled, irqHandled});
        rst = 1'b0;
        activeCycles = 0;
        vecMask = '0;
        while (resetActive && (activeCycles < 16)) begin   // bounded in case it never ends
            if (activeCycles < 7) begin
                vecMask[activeCycles] = controlWord[ctlVecFetch];
            end
            checkValue("reset handled flags", 0, {nmiHandled, irqHandled});
            activeCycles++;
            @(posedge phi1);
            #0.5;
        end
        checkValue("reset length", 7, activeCycles);
        checkValue("reset vector fetch", 7'b1100000, vecMask);  // cycles 6 and 7
        checkValue("first sync", 1, sync);
    endtask

    // starts 0.5 ns after the edge that raised sync and returns at the next sync
    task automatic runRow(input int idx);
        string       name;
        opcodeT      expOpcode;
        int          enabled;
        int          stallsLeft;
        int          nmiPulses;
        int          irqPulses;
        int          lateStray;
        logic        pageFixSeen;
        logic        stallNow;
        logic        done;
        logic        snapSync;
        opcodeT      snapOp;
        controlWordT snapCw;
        name        = rowName[idx];
        expOpcode   = (rowHandled[idx] != 2'b00) ? brkOpcode : rowOpcode[idx];  // forced BRK
        enabled     = 0;
        stallsLeft  = rowStalls[idx];
        nmiPulses   = 0;
        irqPulses   = 0;
        lateStray   = 0;
        pageFixSeen = 1'b0;
        done        = 1'b0;
        opcode      = rowOpcode[idx];
        statusReg   = rowStatus[idx];
        acr         = rowAcr[idx];
        {nmi, irq}  = rowReq[idx];
        while (!done) begin
            stallNow = (stallsLeft > 0) && (($random(seed) & 1) != 0);
            if (stallNow) begin
                stallsLeft--;
            end
            rdy = !stallNow;
            #1;                                 // handled flags follow rdy directly
            if (nmiHandled) nmiPulses++;
            if (irqHandled) irqPulses++;
            snapSync = sync;
            snapOp   = activeOpcode;
            snapCw   = controlWord;
            @(posedge phi1);
            #0.5;
            if (stallNow) begin
                checkValue({name, " stall hold"}, {snapOp, snapCw}, {activeOpcode, controlWord});
                checkValue({name, " stall sync"}, snapSync, sync);
            end else begin
                enabled++;
                if (enabled == 1) begin         // word for T1 just registered
                    checkValue({name, " opcode"}, expOpcode, activeOpcode);
                    checkValue({name, " op fetch"}, 1, controlWord[ctlOpFetch]);
                    checkValue({name, " late write"}, rowLate[idx], controlWord[ctlLateWrite]);
                end else if (controlWord[ctlLateWrite]) begin
                    lateStray++;
                end
                if (controlWord[ctlPageFix]) pageFixSeen = 1'b1;
                done = sync;
            end
        end
        checkValue({name, " length"}, rowLen[idx], enabled);
        checkValue({name, " nmi handled"}, rowHandled[idx][1], nmiPulses);
        checkValue({name, " irq handled"}, rowHandled[idx][0], irqPulses);
        checkValue({name, " page fix"}, rowPageFix[idx], pageFixSeen);
        checkValue({name, " stray late write"}, 0, lateStray);
    endtask

    // watchdog sized from the table length
    initial begin
        #(rowCount * 12 * clkPeriod + 200.0);
        $display("watchdog: run timed out before the last instruction finished");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        seed       = 32'hac4de233;
        checkCount = 0;
        errorCount = 0;
        fillIdx    = 0;
        rst        = 1'b1;
        rdy        = 1'b1;
        nmi        = 1'b0;
        irq        = 1'b0;
        acr        = 1'b0;
        opcode     = 8'hea;
        statusReg  = 8'h00;

        //     name               op     status carry stall req    len handled late fix
        addRow("lda_imm_len4",    8'ha9, 8'h00, 1'b0, 0, 2'b00, 4, 2'b00, 1'b0, 1'b0);
        addRow("ldx_imm_len2",    8'ha2, 8'h00, 1'b0, 0, 2'b00, 2, 2'b00, 1'b1, 1'b0);
        addRow("lda_zp_len3",     8'ha5, 8'h00, 1'b0, 0, 2'b00, 3, 2'b00, 1'b0, 1'b0);
        addRow("lda_abs_len5",    8'had, 8'h00, 1'b1, 0, 2'b00, 5, 2'b00, 1'b1, 1'b0);
        addRow("asl_zp_rmw",      8'h06, 8'h00, 1'b0, 0, 2'b00, 5, 2'b00, 1'b1, 1'b0);
        addRow("stx_abs_norm",    8'h8e, 8'h00, 1'b0, 0, 2'b00, 5, 2'b00, 1'b0, 1'b0);
        addRow("bpl_not_taken",   8'h10, 8'h80, 1'b0, 0, 2'b00, 2, 2'b00, 1'b0, 1'b0);
        addRow("bcc_taken_near",  8'h90, 8'h00, 1'b0, 0, 2'b00, 3, 2'b00, 1'b0, 1'b0);
        addRow("beq_taken_far",   8'hf0, 8'h02, 1'b1, 0, 2'b00, 4, 2'b00, 1'b0, 1'b1);
        addRow("bvs_not_taken",   8'h70, 8'h00, 1'b1, 0, 2'b00, 2, 2'b00, 1'b0, 1'b0);
        addRow("bvc_taken_stall", 8'h50, 8'h00, 1'b1, 3, 2'b00, 4, 2'b00, 1'b0, 1'b1);
        addRow("inc_rmw_stall",   8'he6, 8'h00, 1'b0, 4, 2'b00, 5, 2'b00, 1'b0, 1'b0);
        addRow("ora_abs_stall",   8'h0d, 8'h00, 1'b0, 3, 2'b00, 5, 2'b00, 1'b0, 1'b0);
        addRow("brk_soft",        8'h00, 8'h00, 1'b0, 0, 2'b00, 7, 2'b00, 1'b1, 1'b0);
        addRow("irq_request",     8'ha5, 8'h00, 1'b0, 0, 2'b01, 3, 2'b00, 1'b0, 1'b0);
        addRow("irq_entry",       8'hea, 8'h00, 1'b0, 0, 2'b00, 7, 2'b01, 1'b1, 1'b0);
        addRow("nmi_irq_request", 8'ha2, 8'h00, 1'b0, 0, 2'b11, 2, 2'b00, 1'b0, 1'b0);
        addRow("nmi_entry",       8'hea, 8'h00, 1'b0, 2, 2'b01, 7, 2'b10, 1'b0, 1'b0);
        addRow("irq_after_nmi",   8'ha9, 8'h00, 1'b0, 0, 2'b01, 4, 2'b00, 1'b0, 1'b0);
        addRow("irq_entry_late",  8'hea, 8'h00, 1'b0, 0, 2'b00, 7, 2'b01, 1'b1, 1'b0);
        addRow("lda_after_irq",   8'ha9, 8'h00, 1'b0, 2, 2'b00, 4, 2'b00, 1'b0, 1'b0);

        runReset();
        for (int i = 0; i < rowCount; i++) begin
            runRow(i);
        end

        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+logic
logic/cpuCtlPkg.sv
logic/predecodeReg.sv
logic/instrClassifier.sv
logic/interruptLatch.sv
logic/timingSequencer.sv
logic/controlRom.sv
logic/cpuControl.sv
verification/cpuControlTb.sv
